// File: cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// geometry of one cache, sized for simulation
`define CACHE_LINES 16
`define LINE_BYTES  16

// shared backing store
`define MEM_LINES   256
`define MEM_LATENCY 3   // cycles from accept to done

// caches sharing the one memory
`define NUM_PORTS   2

`endif

// File: cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [8*`LINE_BYTES-1:0] line_t;

    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;
    typedef logic [$clog2(`LINE_BYTES)-1:0] offset_t;
    typedef logic [$bits(addr_t)-$bits(index_t)-$bits(offset_t)-1:0] tag_t;
    typedef logic [$bits(addr_t)-$bits(offset_t)-1:0] line_addr_t;  // address without offset

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FLUSH_SCAN,
        FLUSH_WB,
        DONE
    } ctrl_state_t;

    // one line transfer between a cache and the backing store
    typedef struct packed {
        logic       valid;
        logic       write;
        line_addr_t line_addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;   // single cycle
        line_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::addr_t      addr,
    input  logic                  wr_en,
    input  cache_pkg::word_t      wdata,
    input  logic                  refill_en,
    input  cache_pkg::line_t      refill_data,
    input  logic                  flush_en,
    input  logic                  flush_step,
    output logic                  hit,
    output logic                  dirty,
    output cache_pkg::word_t      rdata,
    output cache_pkg::line_addr_t victim_addr,
    output cache_pkg::line_t      victim_data,
    output logic                  flush_last
);
    import cache_pkg::*;

    line_t                   data_mem [`CACHE_LINES];
    tag_t                    tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    tag_t    addr_tag;
    index_t  addr_index;
    offset_t offset;
    index_t  index;
    index_t  flush_cnt;

    assign {addr_tag, addr_index, offset} = addr;

    // flush counter takes over the index while a flush runs
    assign index = flush_en ? flush_cnt : addr_index;

    assign hit         = valid_q[index] && (tag_mem[index] == addr_tag);
    assign dirty       = valid_q[index] && dirty_q[index];
    assign rdata       = data_mem[index][offset[3:2]*$bits(word_t) +: $bits(word_t)];
    assign victim_addr = {tag_mem[index], index};   // line currently held at this index
    assign victim_data = data_mem[index];
    assign flush_last  = (flush_cnt == index_t'(`CACHE_LINES - 1));

    // line data and tags
    always_ff @(posedge clk) begin
        if (refill_en) begin
            data_mem[index] <= refill_data;
            tag_mem[index]  <= addr_tag;
        end else if (wr_en) begin
            data_mem[index][offset[3:2]*$bits(word_t) +: $bits(word_t)] <= wdata;
        end
    end

    // valid / dirty bits and the flush walk
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q   <= '0;
            dirty_q   <= '0;
            flush_cnt <= '0;
        end else begin
            if (refill_en) begin
                valid_q[index] <= 1'b1;
                dirty_q[index] <= 1'b0;   // fresh copy of memory
            end else if (wr_en) begin
                dirty_q[index] <= 1'b1;
            end

            if (flush_step) begin
                valid_q[index] <= 1'b0;
                dirty_q[index] <= 1'b0;
                flush_cnt      <= flush_cnt + index_t'(1);   // wraps back to line 0
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    // apb slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  cache_pkg::addr_t      paddr,
    input  cache_pkg::word_t      pwdata,
    output cache_pkg::word_t      prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  flush,
    output logic                  flush_done,
    // datapath
    output cache_pkg::addr_t      addr,
    output logic                  wr_en,
    output cache_pkg::word_t      wdata,
    output logic                  refill_en,
    output cache_pkg::line_t      refill_data,
    output logic                  flush_en,
    output logic                  flush_step,
    input  logic                  hit,
    input  logic                  dirty,
    input  cache_pkg::word_t      rdata,
    input  cache_pkg::line_addr_t victim_addr,
    input  cache_pkg::line_t      victim_data,
    input  logic                  flush_last,
    // shared memory
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_done,
    input  cache_pkg::line_t      mem_rdata
);
    import cache_pkg::*;

    localparam addr_t mem_bytes = addr_t'(`MEM_LINES * `LINE_BYTES);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        flushing;   // DONE belongs to a flush, not to apb
    logic        addr_err;

    assign addr_err = (paddr[1:0] != 2'b00) || (paddr >= mem_bytes);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= IDLE;
            flushing <= 1'b0;
        end else begin
            state <= next_state;
            if (state == IDLE)
                flushing <= (next_state == FLUSH_SCAN);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (psel)
                    next_state = LOOKUP;   // apb wins over a pending flush
                else if (flush)
                    next_state = FLUSH_SCAN;
            end
            LOOKUP: begin
                if (addr_err || hit)
                    next_state = DONE;
                else if (dirty)
                    next_state = WRITEBACK;
                else
                    next_state = REFILL;
            end
            WRITEBACK:  if (mem_done) next_state = REFILL;
            REFILL:     if (mem_done) next_state = LOOKUP;   // replay, now a hit
            FLUSH_SCAN: begin
                if (dirty)
                    next_state = FLUSH_WB;
                else if (flush_last)
                    next_state = DONE;
            end
            FLUSH_WB:   if (mem_done) next_state = flush_last ? DONE : FLUSH_SCAN;
            DONE:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    assign addr        = paddr;
    assign wdata       = pwdata;
    assign prdata      = rdata;
    assign refill_data = mem_rdata;   // broadcast line, loaded only on our own done
    assign wr_en       = (state == LOOKUP) && pwrite && hit && !addr_err;
    assign refill_en   = (state == REFILL) && mem_done;
    assign flush_en    = (state == FLUSH_SCAN) || (state == FLUSH_WB);
    assign flush_step  = ((state == FLUSH_SCAN) && !dirty) || ((state == FLUSH_WB) && mem_done);
    assign pready      = (state == DONE) && !flushing;
    assign pslverr     = pready && addr_err;
    assign flush_done  = (state == DONE) && flushing;

    always_comb begin
        mem_req = '0;
        case (state)
            WRITEBACK, FLUSH_WB: begin
                mem_req.valid     = 1'b1;
                mem_req.write     = 1'b1;
                mem_req.line_addr = victim_addr;
                mem_req.wdata     = victim_data;
            end
            REFILL: begin
                mem_req.valid     = 1'b1;
                mem_req.line_addr = paddr[31 -: $bits(line_addr_t)];
            end
            default: ;
        endcase
    end

    // request must not move while it waits for the arbiter and memory
    req_hold_a: assert property (@(posedge clk) disable iff (!reset)
        mem_req.valid && !mem_done |=> $stable(mem_req))
        else $error("cache_ctrl: memory request changed before done");

    pready_phase_a: assert property (@(posedge clk) disable iff (!reset)
        $rose(pready) |-> psel && penable)
        else $error("cache_ctrl: pready raised outside an access phase");

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::mem_req_t    req [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0]  done,
    output cache_pkg::mem_req_t    mem_req,
    input  logic                   mem_done
);
    import cache_pkg::*;

    localparam int port_bits = $clog2(`NUM_PORTS);
    typedef logic [port_bits-1:0] port_t;

    port_t grant;
    port_t last;   // last winner
    port_t pick;
    logic  busy;
    logic  any_req;
    logic  other_wait;   // someone besides the granted port is asking

    // search starts just after the last winner
    always_comb begin
        int cand;
        pick    = last;
        any_req = 1'b0;
        for (int i = 1; i <= `NUM_PORTS; i++) begin
            cand = (int'(last) + i) % `NUM_PORTS;
            if (!any_req && req[cand].valid) begin
                pick    = cand[port_bits-1:0];
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        other_wait = 1'b0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (i != int'(grant) && req[i].valid)
                other_wait = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy  <= 1'b0;
            grant <= '0;
            last  <= port_t'(`NUM_PORTS - 1);   // port 0 goes first
        end else if (!busy) begin
            if (any_req) begin
                busy  <= 1'b1;
                grant <= pick;
                last  <= pick;
            end
        end else if (mem_done) begin
            busy <= 1'b0;   // memory free again next cycle
        end
    end

    assign mem_req = busy ? req[grant] : '0;

    always_comb begin
        done        = '0;
        done[grant] = busy && mem_done;
    end

    // a waiting port is served before the port that just finished
    rr_turn_a: assert property (@(posedge clk) disable iff (!reset)
        busy && mem_done && other_wait |-> ##2 busy && grant != $past(grant, 2))
        else $error("mem_arbiter: waiting port skipped after memory done");

    // memory only finishes what a live requester asked for
    done_owner_a: assert property (@(posedge clk) disable iff (!reset)
        mem_done |-> busy && req[grant].valid)
        else $error("mem_arbiter: done without a valid granted request");

endmodule

`default_nettype wire

// File: line_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module line_memory (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);
    import cache_pkg::*;

    localparam int idx_bits = $clog2(`MEM_LINES);
    localparam int cnt_bits = $clog2(`MEM_LATENCY + 1);
    typedef logic [cnt_bits-1:0] count_t;

    line_t               mem [`MEM_LINES];
    logic [idx_bits-1:0] idx;
    count_t              count;   // zero when idle

    assign idx       = req.line_addr[idx_bits-1:0];   // low line bits only
    assign rsp.done  = (count == count_t'(1));
    assign rsp.rdata = mem[idx];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
            for (int i = 0; i < `MEM_LINES; i++)
                mem[i] <= '0;
        end else begin
            if (count != '0)
                count <= count - count_t'(1);
            else if (req.valid)
                count <= count_t'(`MEM_LATENCY);   // accept
            if (rsp.done && req.write)
                mem[idx] <= req.wdata;   // write lands with done
        end
    end

endmodule

`default_nettype wire

// File: dual_cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dual_cache_top (
    input  logic             clk,
    input  logic             reset,
    // port 0
    input  logic             psel_0,
    input  logic             penable_0,
    input  logic             pwrite_0,
    input  cache_pkg::addr_t paddr_0,
    input  cache_pkg::word_t pwdata_0,
    output cache_pkg::word_t prdata_0,
    output logic             pready_0,
    output logic             pslverr_0,
    input  logic             flush_0,
    output logic             flush_done_0,
    // port 1
    input  logic             psel_1,
    input  logic             penable_1,
    input  logic             pwrite_1,
    input  cache_pkg::addr_t paddr_1,
    input  cache_pkg::word_t pwdata_1,
    output cache_pkg::word_t prdata_1,
    output logic             pready_1,
    output logic             pslverr_1,
    input  logic             flush_1,
    output logic             flush_done_1
);
    import cache_pkg::*;

    // controller <-> datapath, one entry per cache
    addr_t                 dp_addr        [`NUM_PORTS];
    word_t                 dp_wdata       [`NUM_PORTS];
    word_t                 dp_rdata       [`NUM_PORTS];
    line_t                 dp_refill_data [`NUM_PORTS];
    line_t                 dp_victim_data [`NUM_PORTS];
    line_addr_t            dp_victim_addr [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] dp_wr_en;
    logic [`NUM_PORTS-1:0] dp_refill_en;
    logic [`NUM_PORTS-1:0] dp_flush_en;
    logic [`NUM_PORTS-1:0] dp_flush_step;
    logic [`NUM_PORTS-1:0] dp_hit;
    logic [`NUM_PORTS-1:0] dp_dirty;
    logic [`NUM_PORTS-1:0] dp_flush_last;

    // caches <-> arbiter <-> memory
    mem_req_t              cache_req [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] cache_done;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;

    cache_ctrl u_ctrl_0 (
        .clk(clk), .reset(reset),
        .psel(psel_0), .penable(penable_0), .pwrite(pwrite_0),
        .paddr(paddr_0), .pwdata(pwdata_0), .prdata(prdata_0),
        .pready(pready_0), .pslverr(pslverr_0),
        .flush(flush_0), .flush_done(flush_done_0),
        .addr(dp_addr[0]), .wr_en(dp_wr_en[0]), .wdata(dp_wdata[0]),
        .refill_en(dp_refill_en[0]), .refill_data(dp_refill_data[0]),
        .flush_en(dp_flush_en[0]), .flush_step(dp_flush_step[0]),
        .hit(dp_hit[0]), .dirty(dp_dirty[0]), .rdata(dp_rdata[0]),
        .victim_addr(dp_victim_addr[0]), .victim_data(dp_victim_data[0]),
        .flush_last(dp_flush_last[0]),
        .mem_req(cache_req[0]), .mem_done(cache_done[0]), .mem_rdata(mem_rsp.rdata)
    );

    cache_datapath u_datapath_0 (
        .clk(clk), .reset(reset),
        .addr(dp_addr[0]), .wr_en(dp_wr_en[0]), .wdata(dp_wdata[0]),
        .refill_en(dp_refill_en[0]), .refill_data(dp_refill_data[0]),
        .flush_en(dp_flush_en[0]), .flush_step(dp_flush_step[0]),
        .hit(dp_hit[0]), .dirty(dp_dirty[0]), .rdata(dp_rdata[0]),
        .victim_addr(dp_victim_addr[0]), .victim_data(dp_victim_data[0]),
        .flush_last(dp_flush_last[0])
    );

    cache_ctrl u_ctrl_1 (
        .clk(clk), .reset(reset),
        .psel(psel_1), .penable(penable_1), .pwrite(pwrite_1),
        .paddr(paddr_1), .pwdata(pwdata_1), .prdata(prdata_1),
        .pready(pready_1), .pslverr(pslverr_1),
        .flush(flush_1), .flush_done(flush_done_1),
        .addr(dp_addr[1]), .wr_en(dp_wr_en[1]), .wdata(dp_wdata[1]),
        .refill_en(dp_refill_en[1]), .refill_data(dp_refill_data[1]),
        .flush_en(dp_flush_en[1]), .flush_step(dp_flush_step[1]),
        .hit(dp_hit[1]), .dirty(dp_dirty[1]), .rdata(dp_rdata[1]),
        .victim_addr(dp_victim_addr[1]), .victim_data(dp_victim_data[1]),
        .flush_last(dp_flush_last[1]),
        .mem_req(cache_req[1]), .mem_done(cache_done[1]), .mem_rdata(mem_rsp.rdata)
    );

    cache_datapath u_datapath_1 (
        .clk(clk), .reset(reset),
        .addr(dp_addr[1]), .wr_en(dp_wr_en[1]), .wdata(dp_wdata[1]),
        .refill_en(dp_refill_en[1]), .refill_data(dp_refill_data[1]),
        .flush_en(dp_flush_en[1]), .flush_step(dp_flush_step[1]),
        .hit(dp_hit[1]), .dirty(dp_dirty[1]), .rdata(dp_rdata[1]),
        .victim_addr(dp_victim_addr[1]), .victim_data(dp_victim_data[1]),
        .flush_last(dp_flush_last[1])
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .reset(reset),
        .req(cache_req), .done(cache_done),
        .mem_req(mem_req), .mem_done(mem_rsp.done)
    );

    line_memory u_line_memory (
        .clk(clk), .reset(reset),
        .req(mem_req), .rsp(mem_rsp)
    );

endmodule

`default_nettype wire

// File: tb_dual_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module tb_dual_cache;
    import cache_pkg::*;

    localparam int    clk_period  = 10;
    localparam int    rand_ops    = 40;   // per port
    localparam int    miss_cycles = 4 * (`MEM_LATENCY + 2) + 6;   // writeback + refill, contended
    localparam int    op_budget   = 2 * rand_ops + 20 + `CACHE_LINES;
    localparam addr_t mem_bytes   = addr_t'(`MEM_LINES * `LINE_BYTES);

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    logic       clk;
    logic       reset;
    apb_req_t   apb [2];
    logic [1:0] flush;
    word_t      prdata [2];
    logic [1:0] pready;
    logic [1:0] pslverr;
    logic [1:0] flush_done;

    // expectations for the access in flight on each port
    word_t      exp_rdata [2];
    logic [1:0] exp_err;
    logic [1:0] one_wait;

    word_t  shadow [addr_t];   // absent word reads as zero
    addr_t  rand_addr [2][rand_ops];
    word_t  rand_data [2][rand_ops];
    logic   rand_wr   [2][rand_ops];
    integer seed;
    int     tests;
    int     checks;
    int     errors;
    int     errors_before;

    dual_cache_top u_dual_cache_top (
        .clk(clk), .reset(reset),
        .psel_0(apb[0].psel), .penable_0(apb[0].penable), .pwrite_0(apb[0].pwrite),
        .paddr_0(apb[0].paddr), .pwdata_0(apb[0].pwdata), .prdata_0(prdata[0]),
        .pready_0(pready[0]), .pslverr_0(pslverr[0]),
        .flush_0(flush[0]), .flush_done_0(flush_done[0]),
        .psel_1(apb[1].psel), .penable_1(apb[1].penable), .pwrite_1(apb[1].pwrite),
        .paddr_1(apb[1].paddr), .pwdata_1(apb[1].pwdata), .prdata_1(prdata[1]),
        .pready_1(pready[1]), .pslverr_1(pslverr[1]),
        .flush_1(flush[1]), .flush_done_1(flush_done[1])
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic addr_is_bad(input addr_t addr);
        return (addr[1:0] != 2'b00) || (addr >= mem_bytes);
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        return shadow.exists(addr) ? shadow[addr] : '0;
    endfunction

    task automatic report_value(input string name, input int port, input word_t got,
                                input word_t exp);
        errors++;
        $display("[ERROR] %s_%0d got %h expected %h", name, port, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    for (genvar p = 0; p < 2; p++) begin : g_port_check
        rdata_a: assert property (@(posedge clk) disable iff (!reset)
            apb[p].psel && apb[p].penable && pready[p] && !apb[p].pwrite && !exp_err[p]
            |-> prdata[p] == exp_rdata[p])
            else report_value("prdata", p, $sampled(prdata[p]), $sampled(exp_rdata[p]));

        pslverr_a: assert property (@(posedge clk) disable iff (!reset)
            apb[p].psel && apb[p].penable && pready[p] |-> pslverr[p] == exp_err[p])
            else report_value("pslverr", p, 32'($sampled(pslverr[p])),
                              32'($sampled(exp_err[p])));

        // hits and address errors end after one wait state, misses take longer
        wait_a: assert property (@(posedge clk) disable iff (!reset)
            $rose(apb[p].penable) |-> !pready[p] ##1 (pready[p] || !one_wait[p]))
            else report_failure($sformatf("port %0d access missed its one wait state", p));

        flush_done_a: assert property (@(posedge clk) disable iff (!reset)
            flush_done[p] |-> flush[p] ##1 !flush_done[p])
            else report_failure($sformatf("port %0d flush_done not one pulse in a flush", p));
    end

    // entered and left on a falling edge
    task automatic apb_access(input int port, input logic write, input addr_t addr,
                              input word_t data);
        logic bad;
        bad               = addr_is_bad(addr);
        exp_err[port]     = bad;
        exp_rdata[port]   = expected_word(addr);
        apb[port].psel    = 1'b1;
        apb[port].penable = 1'b0;
        apb[port].pwrite  = write;
        apb[port].paddr   = addr;
        apb[port].pwdata  = data;
        @(negedge clk);
        apb[port].penable = 1'b1;
        @(negedge clk);
        while (!pready[port])
            @(negedge clk);
        @(negedge clk);   // transfer ends on the rising edge just passed
        apb[port] = '0;
        if (write && !bad)
            shadow[addr] = data;
        checks++;
    endtask

    task automatic flush_cache(input int port);
        flush[port] = 1'b1;
        @(negedge clk);
        while (!flush_done[port])
            @(negedge clk);
        @(negedge clk);
        flush[port] = 1'b0;
        checks++;
    endtask

    task automatic run_random(input int port);
        for (int i = 0; i < rand_ops; i++)
            apb_access(port, rand_wr[port][i], rand_addr[port][i], rand_data[port][i]);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin : watchdog
        #(op_budget * miss_cycles * clk_period);
        $display("error: run did not finish within %0d cycles", op_budget * miss_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        seed          = 32'h03e6f1a2;
        tests         = 0;
        checks        = 0;
        errors        = 0;
        errors_before = 0;
        reset         = 1'b0;
        apb[0]        = '0;
        apb[1]        = '0;
        flush         = '0;
        exp_rdata[0]  = '0;
        exp_rdata[1]  = '0;
        exp_err       = '0;
        one_wait      = '0;
        repeat (4) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        apb_access(0, 1'b1, 32'h040, 32'hcafe_0001);
        apb_access(0, 1'b0, 32'h040, 32'h0);
        apb_access(0, 1'b0, 32'h080, 32'h0);   // never written
        end_test("write then read");

        // index 0 with tags 1 and 2
        apb_access(0, 1'b1, 32'h100, 32'h1111_aaaa);
        apb_access(0, 1'b1, 32'h200, 32'h2222_bbbb);
        apb_access(0, 1'b0, 32'h100, 32'h0);
        apb_access(0, 1'b0, 32'h200, 32'h0);
        end_test("conflict eviction");

        apb_access(0, 1'b1, 32'h344, 32'h3333_cccc);
        one_wait[0] = 1'b1;
        apb_access(0, 1'b0, 32'h344, 32'h0);
        one_wait[0] = 1'b0;
        end_test("hit timing");

        one_wait[0] = 1'b1;
        apb_access(0, 1'b1, 32'h346, 32'hdead_beef);   // misaligned
        apb_access(0, 1'b0, 32'h1000, 32'h0);          // past the backing store
        one_wait[0] = 1'b0;
        apb_access(0, 1'b0, 32'h344, 32'h0);
        end_test("address errors");

        apb_access(0, 1'b1, 32'h500, 32'h5555_eeee);
        flush_cache(0);
        apb_access(1, 1'b0, 32'h500, 32'h0);
        one_wait[1] = 1'b1;
        apb_access(1, 1'b0, 32'h500, 32'h0);   // now a hit
        one_wait[1] = 1'b0;
        end_test("flush then other port read");

        // port 0 below 0x400, port 1 from 0x800
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < rand_ops; i++) begin
                rand_addr[p][i] = ((p == 0) ? 32'h000 : 32'h800) | ($random(seed) & 32'h3fc);
                rand_data[p][i] = $random(seed);
                rand_wr[p][i]   = 1'($random(seed));
            end
        end
        fork
            run_random(0);
            run_random(1);
        join
        end_test("random traffic");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dual_cache_top.f
+incdir+.
cache_pkg.sv
cache_datapath.sv
cache_ctrl.sv
mem_arbiter.sv
line_memory.sv
dual_cache_top.sv
tb_dual_cache.sv

// File: Bender.yml
package:
  name: dual_cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_datapath.sv
      - cache_ctrl.sv
      - mem_arbiter.sv
      - line_memory.sv
      - dual_cache_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dual_cache.sv
